//--- Makefile
# Verilator build and run of the out-of-order back end testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/clock_gen.sv
// testbench clock and power-on reset generator

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clock,
	output logic rst
);
	// 4 ns period
	localparam real HALF_PERIOD  = 2.0;
	localparam int  RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// held for the first cycles, released just after an edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/tb_ooo_backend.sv
// testbench top with directed tests, reference model, commit monitor and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module tb_ooo_backend;
	import ooo_pkg::*;

	// operation counts that size the watchdog
	localparam int RANDOM_OPS      = 200;
	localparam int TOTAL_OPS       = 9 + 9 + 9 + 16 + RANDOM_OPS;
	localparam int WATCHDOG_CYCLES = 20 + 200 * TOTAL_OPS;

	typedef struct packed {
		rob_tag_t  tag;
		arch_reg_t dest;
		data_t     data;
	} commit_t;

	logic       clock;
	logic       rst;
	logic       dispatch_valid;
	alu_op_t    dispatch_op;
	arch_reg_t  dispatch_dest;
	logic       src_a_wait;
	rob_tag_t   src_a_tag;
	data_t      src_a_value;
	logic       src_b_wait;
	rob_tag_t   src_b_tag;
	data_t      src_b_value;
	logic       dispatch_free;
	rob_tag_t   dispatch_tag;
	rob_count_t rob_free_count;
	logic       commit_valid;
	rob_tag_t   commit_tag;
	arch_reg_t  commit_dest;
	data_t      commit_data;

	// reference model state
	commit_t    exp_q [$];
	data_t      model_val [8];
	logic [7:0] pending;
	rob_tag_t   next_tag;
	int         dispatched;
	int         committed;
	logic       saw_full;
	logic       monitor_on;
	string      test_name;

	clock_gen u_clock_gen (.clock(clock), .rst(rst));

	ooo_backend uut (
		.clock(clock), .rst(rst),
		.dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
		.dispatch_dest(dispatch_dest),
		.src_a_wait(src_a_wait), .src_a_tag(src_a_tag), .src_a_value(src_a_value),
		.src_b_wait(src_b_wait), .src_b_tag(src_b_tag), .src_b_value(src_b_value),
		.dispatch_free(dispatch_free), .dispatch_tag(dispatch_tag),
		.rob_free_count(rob_free_count),
		.commit_valid(commit_valid), .commit_tag(commit_tag),
		.commit_dest(commit_dest), .commit_data(commit_data)
	);

	////////////////////
	// checking
	////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string what, input data_t expected, input data_t actual);
		if (expected !== actual) begin
			$display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
			abort_run("run stopped at the first mismatch");
		end
	endtask

	// opcode rules
	function automatic data_t expected_result(input alu_op_t op, input data_t a, input data_t b);
		case (op)
			`OOO_OP_ADD: return a + b;
			`OOO_OP_SUB: return a - b;
			`OOO_OP_AND: return a & b;
			`OOO_OP_OR:  return a | b;
			`OOO_OP_XOR: return a ^ b;
			`OOO_OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`OOO_OP_SLL: return a << b[4:0];
			default:     return '0;
		endcase
	endfunction

	// commits and occupancy against the model on every cycle out of reset
	always @(negedge clock) begin
		commit_t entry;
		if (monitor_on) begin
			if (commit_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("commit seen with no operation outstanding");
				end else begin
					entry = exp_q.pop_front();
					check_value("commit_tag", data_t'(entry.tag), data_t'(commit_tag));
					check_value("commit_dest", data_t'(entry.dest), data_t'(commit_dest));
					check_value("commit_data", entry.data, commit_data);
					pending[entry.tag] = 1'b0;
					committed++;
				end
			end
			// occupancy as the model counts it
			if (dispatched - committed > 8)
				abort_run("more than eight operations outstanding");
			else
				check_value("rob_free_count", data_t'(8 - (dispatched - committed)),
					data_t'(rob_free_count));
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		abort_run("watchdog timeout, operations did not finish committing");
	end

	////////////////////
	// stimulus
	////////////////////

	// starts and ends 1 ns after a rising edge
	task automatic send_op(input alu_op_t op, input arch_reg_t dest,
			input logic a_dep, input rob_tag_t a_src, input data_t a_lit,
			input logic b_dep, input rob_tag_t b_src, input data_t b_lit,
			output rob_tag_t tag);
		logic    a_wait;
		logic    b_wait;
		data_t   a_v;
		data_t   b_v;
		commit_t entry;
		// stall while either structure is full
		while (!dispatch_free) begin
			saw_full = 1'b1;
			@(posedge clock);
			#1;
		end
		check_value("dispatch_tag", data_t'(next_tag), data_t'(dispatch_tag));
		// committed producer goes out as a plain value
		a_wait = a_dep && pending[a_src];
		b_wait = b_dep && pending[b_src];
		a_v    = a_dep ? model_val[a_src] : a_lit;
		b_v    = b_dep ? model_val[b_src] : b_lit;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_dest  = dest;
		src_a_wait     = a_wait;
		src_a_tag      = a_wait ? a_src : '0;
		// inverted value while waiting so a stale operand shows up
		src_a_value    = a_wait ? ~a_v : a_v;
		src_b_wait     = b_wait;
		src_b_tag      = b_wait ? b_src : '0;
		src_b_value    = b_wait ? ~b_v : b_v;
		tag        = next_tag;
		entry.tag  = next_tag;
		entry.dest = dest;
		entry.data = expected_result(op, a_v, b_v);
		@(posedge clock);
		// accepted at this edge
		model_val[tag] = entry.data;
		pending[tag]   = 1'b1;
		exp_q.push_back(entry);
		dispatched++;
		next_tag = next_tag + 1'b1;
		#1;
		dispatch_valid = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#1;
		end
	endtask

	// until every dispatched op has committed
	task automatic drain();
		while (dispatched != committed) begin
			@(posedge clock);
			#1;
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic reset_state();
		test_name = "reset_state";
		check_value("rob_free_count", 32'd8, data_t'(rob_free_count));
		check_value("dispatch_free", 32'd1, data_t'(dispatch_free));
		check_value("dispatch_tag", 32'd0, data_t'(dispatch_tag));
		for (int i = 0; i < 4; i++) begin
			check_value("commit_valid", 32'd0, data_t'(commit_valid));
			idle(1);
		end
	endtask

	task automatic independent_ops();
		rob_tag_t t;
		test_name = "independent_ops";
		send_op(`OOO_OP_ADD, 5'd1, 1'b0, '0, 32'd5, 1'b0, '0, 32'd7, t);
		send_op(`OOO_OP_SUB, 5'd2, 1'b0, '0, 32'd3, 1'b0, '0, 32'd10, t);
		send_op(`OOO_OP_AND, 5'd3, 1'b0, '0, 32'hf0f0_1234, 1'b0, '0, 32'h0ff0_ffff, t);
		send_op(`OOO_OP_OR, 5'd4, 1'b0, '0, 32'h0000_ff00, 1'b0, '0, 32'h1200_0034, t);
		send_op(`OOO_OP_XOR, 5'd5, 1'b0, '0, 32'haaaa_5555, 1'b0, '0, 32'hffff_0000, t);
		// negative below positive
		send_op(`OOO_OP_SLT, 5'd6, 1'b0, '0, 32'hffff_fffb, 1'b0, '0, 32'd3, t);
		send_op(`OOO_OP_SLT, 5'd7, 1'b0, '0, 32'd7, 1'b0, '0, 32'hffff_fffe, t);
		// only the low five bits of b shift
		send_op(`OOO_OP_SLL, 5'd8, 1'b0, '0, 32'h1, 1'b0, '0, 32'h24, t);
		send_op(`OOO_OP_SLL, 5'd9, 1'b0, '0, 32'h8000_0003, 1'b0, '0, 32'd31, t);
		drain();
	endtask

	task automatic dependency_chain();
		rob_tag_t prev;
		rob_tag_t t;
		alu_op_t  op;
		test_name = "dependency_chain";
		send_op(`OOO_OP_ADD, 5'd10, 1'b0, '0, 32'd3, 1'b0, '0, 32'd4, prev);
		for (int i = 0; i < 8; i++) begin
			case (i % 4)
				0:       op = `OOO_OP_ADD;
				1:       op = `OOO_OP_XOR;
				2:       op = `OOO_OP_SUB;
				default: op = `OOO_OP_SLL;
			endcase
			send_op(op, arch_reg_t'(11 + i), 1'b1, prev, '0, 1'b0, '0, data_t'(i + 1), t);
			prev = t;
		end
		drain();
	endtask

	task automatic forwarding_and_order();
		rob_tag_t chain;
		rob_tag_t prod;
		rob_tag_t t;
		test_name = "forwarding_and_order";
		// slow chain holds the rob head
		send_op(`OOO_OP_ADD, 5'd20, 1'b0, '0, 32'd100, 1'b0, '0, 32'd1, chain);
		for (int i = 0; i < 3; i++)
			send_op(`OOO_OP_SUB, 5'd20, 1'b1, chain, '0, 1'b0, '0, 32'd2, chain);
		// completes well before the chain ahead of it
		send_op(`OOO_OP_XOR, 5'd21, 1'b0, '0, 32'h1234_5678, 1'b0, '0, 32'h0f0f_0f0f, prod);
		idle(4);
		check_value("producer still pending", 32'd1, data_t'(pending[prod]));
		send_op(`OOO_OP_ADD, 5'd22, 1'b1, prod, '0, 1'b0, '0, 32'd1, t);
		send_op(`OOO_OP_SUB, 5'd23, 1'b1, prod, '0, 1'b1, chain, '0, t);
		send_op(`OOO_OP_OR, 5'd24, 1'b0, '0, 32'h55, 1'b0, '0, 32'haa, t);
		send_op(`OOO_OP_AND, 5'd25, 1'b1, t, '0, 1'b1, prod, '0, t);
		drain();
	endtask

	task automatic full_backpressure();
		rob_tag_t chain;
		rob_tag_t t;
		test_name = "full_backpressure";
		saw_full  = 1'b0;
		send_op(`OOO_OP_ADD, 5'd1, 1'b0, '0, 32'd7, 1'b0, '0, 32'd9, chain);
		for (int i = 0; i < 3; i++)
			send_op(`OOO_OP_SLL, 5'd2, 1'b1, chain, '0, 1'b0, '0, 32'd1, chain);
		// independents pile up behind the chain until the rob fills
		for (int i = 0; i < 12; i++)
			send_op(`OOO_OP_XOR, arch_reg_t'(i), 1'b0, '0, data_t'(i * 32'h1111),
				1'b0, '0, 32'hffff, t);
		check_value("dispatch_free dropped", 32'd1, data_t'(saw_full));
		drain();
	endtask

	task automatic random_mix();
		rob_tag_t t;
		rob_tag_t a_src;
		rob_tag_t b_src;
		logic     a_dep;
		logic     b_dep;
		alu_op_t  op;
		test_name = "random_mix";
		for (int i = 0; i < RANDOM_OPS; i++) begin
			op    = alu_op_t'($urandom % 7);
			a_src = rob_tag_t'($urandom % 8);
			b_src = rob_tag_t'($urandom % 8);
			// depend on a tag only while it is in flight
			a_dep = ($urandom % 2 == 0) && pending[a_src];
			b_dep = ($urandom % 2 == 0) && pending[b_src];
			send_op(op, arch_reg_t'($urandom % 32), a_dep, a_src, $urandom,
				b_dep, b_src, $urandom, t);
			// occasional bubble
			if ($urandom % 4 == 0)
				idle(1);
		end
		drain();
	endtask

	initial begin
		dispatch_valid = 1'b0;
		dispatch_op    = '0;
		dispatch_dest  = '0;
		src_a_wait     = 1'b0;
		src_a_tag      = '0;
		src_a_value    = '0;
		src_b_wait     = 1'b0;
		src_b_tag      = '0;
		src_b_value    = '0;
		pending        = '0;
		next_tag       = '0;
		dispatched     = 0;
		committed      = 0;
		saw_full       = 1'b0;
		monitor_on     = 1'b0;
		test_name      = "reset";
		void'($urandom(32'h691));
		@(negedge rst);
		monitor_on = 1'b1;
		reset_state();
		independent_ops();
		dependency_chain();
		forwarding_and_order();
		full_backpressure();
		random_mix();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
// single-cycle alu with registered result driving the cdb

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module alu_unit (
	input  wire logic              clock,
	input  wire logic              rst,
	input  wire logic              issue_valid,
	input  wire ooo_pkg::alu_op_t  issue_op,
	input  wire ooo_pkg::rob_tag_t issue_tag,
	input  wire ooo_pkg::data_t    issue_a,
	input  wire ooo_pkg::data_t    issue_b,
	output logic                   cdb_valid,
	output ooo_pkg::rob_tag_t      cdb_tag,
	output ooo_pkg::data_t         cdb_data
);
	import ooo_pkg::*;

	// shift amount taken from the low bits of b
	localparam int SHAMT_W = $clog2(`OOO_DATA_WIDTH);

	data_t result;

	always_comb begin
		case (issue_op)
			`OOO_OP_ADD: result = issue_a + issue_b;
			`OOO_OP_SUB: result = issue_a - issue_b;
			`OOO_OP_AND: result = issue_a & issue_b;
			`OOO_OP_OR:  result = issue_a | issue_b;
			`OOO_OP_XOR: result = issue_a ^ issue_b;
			// zero-extended compare flag
			`OOO_OP_SLT: result = data_t'($signed(issue_a) < $signed(issue_b));
			`OOO_OP_SLL: result = issue_a << issue_b[SHAMT_W-1:0];
			default:     result = '0;
		endcase
	end

	// broadcast one cycle after issue
	always_ff @(posedge clock) begin
		if (rst)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= issue_valid;
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			cdb_tag  <= issue_tag;
			cdb_data <= result;
		end
	end

endmodule

`default_nettype wire

//--- hw/issue_queue.sv
// reservation-station issue queue with cdb wakeup and oldest-ready select

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module issue_queue (
	input  wire logic              clock,
	input  wire logic              rst,
	input  wire logic              dispatch_valid,
	input  wire ooo_pkg::alu_op_t  dispatch_op,
	input  wire ooo_pkg::rob_tag_t dispatch_tag,
	input  wire logic              src_a_wait,
	input  wire ooo_pkg::rob_tag_t src_a_tag,
	input  wire ooo_pkg::data_t    src_a_value,
	input  wire logic              src_b_wait,
	input  wire ooo_pkg::rob_tag_t src_b_tag,
	input  wire ooo_pkg::data_t    src_b_value,
	input  wire logic              cdb_valid,
	input  wire ooo_pkg::rob_tag_t cdb_tag,
	input  wire ooo_pkg::data_t    cdb_data,
	output logic                   rs_free,
	output logic                   issue_valid,
	output ooo_pkg::alu_op_t       issue_op,
	output ooo_pkg::rob_tag_t      issue_tag,
	output ooo_pkg::data_t         issue_a,
	output ooo_pkg::data_t         issue_b
);
	import ooo_pkg::*;

	localparam int RS_N  = `OOO_RS_DEPTH;
	localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

	typedef logic [IDX_W-1:0] rs_idx_t;

	// entry control
	logic [RS_N-1:0] busy;
	logic [RS_N-1:0] a_rdy;
	logic [RS_N-1:0] b_rdy;
	// age 0 is youngest, busy entries hold a permutation of 0..n-1
	rs_idx_t         age     [RS_N];
	rs_idx_t         age_nxt [RS_N];

	// entry payload
	alu_op_t  op    [RS_N];
	rob_tag_t tag   [RS_N];
	rob_tag_t a_tag [RS_N];
	rob_tag_t b_tag [RS_N];
	data_t    a_val [RS_N];
	data_t    b_val [RS_N];

	// select and allocate
	logic [RS_N-1:0] ready;
	logic [RS_N-1:0] avail;
	logic            sel_valid;
	rs_idx_t         sel_idx;
	rs_idx_t         free_idx;

	// dispatch operands after same-cycle cdb bypass
	logic  dsp_a_rdy;
	logic  dsp_b_rdy;
	data_t dsp_a_val;
	data_t dsp_b_val;

	////////////////////
	// oldest-ready select
	////////////////////

	always_comb begin
		ready     = busy & a_rdy & b_rdy;
		sel_valid = 1'b0;
		sel_idx   = '0;
		for (int i = 0; i < RS_N; i++) begin
			// larger age wins
			if (ready[i] && (!sel_valid || age[i] > age[sel_idx])) begin
				sel_valid = 1'b1;
				sel_idx   = rs_idx_t'(i);
			end
		end
	end

	// free slots, including the one issuing now
	always_comb begin
		avail = ~busy;
		if (sel_valid)
			avail[sel_idx] = 1'b1;
		free_idx = '0;
		for (int i = RS_N - 1; i >= 0; i--) begin
			if (avail[i])
				free_idx = rs_idx_t'(i);
		end
	end

	assign rs_free = |avail;

	// close the gap left by the issued entry, then make room for the new one
	always_comb begin
		for (int i = 0; i < RS_N; i++) begin
			age_nxt[i] = age[i];
			if (sel_valid && age[i] > age[sel_idx])
				age_nxt[i] = age_nxt[i] - 1'b1;
			if (dispatch_valid)
				age_nxt[i] = age_nxt[i] + 1'b1;
		end
	end

	// producer broadcasting in the dispatch cycle
	always_comb begin
		dsp_a_rdy = !src_a_wait;
		dsp_a_val = src_a_value;
		if (src_a_wait && cdb_valid && cdb_tag == src_a_tag) begin
			dsp_a_rdy = 1'b1;
			dsp_a_val = cdb_data;
		end
		dsp_b_rdy = !src_b_wait;
		dsp_b_val = src_b_value;
		if (src_b_wait && cdb_valid && cdb_tag == src_b_tag) begin
			dsp_b_rdy = 1'b1;
			dsp_b_val = cdb_data;
		end
	end

	////////////////////
	// entry state
	////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			busy        <= '0;
			a_rdy       <= '0;
			b_rdy       <= '0;
			issue_valid <= 1'b0;
			for (int i = 0; i < RS_N; i++)
				age[i] <= '0;
		end else begin
			issue_valid <= sel_valid;
			for (int i = 0; i < RS_N; i++) begin
				if (busy[i])
					age[i] <= age_nxt[i];
				// wakeup from the cdb
				if (busy[i] && cdb_valid && a_tag[i] == cdb_tag)
					a_rdy[i] <= 1'b1;
				if (busy[i] && cdb_valid && b_tag[i] == cdb_tag)
					b_rdy[i] <= 1'b1;
			end
			if (sel_valid)
				busy[sel_idx] <= 1'b0;
			// new entry last, it may reuse the issued slot
			if (dispatch_valid) begin
				busy[free_idx]  <= 1'b1;
				age[free_idx]   <= '0;
				a_rdy[free_idx] <= dsp_a_rdy;
				b_rdy[free_idx] <= dsp_b_rdy;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_N; i++) begin
			if (busy[i] && !a_rdy[i] && cdb_valid && a_tag[i] == cdb_tag)
				a_val[i] <= cdb_data;
			if (busy[i] && !b_rdy[i] && cdb_valid && b_tag[i] == cdb_tag)
				b_val[i] <= cdb_data;
		end
		if (dispatch_valid) begin
			op[free_idx]    <= dispatch_op;
			tag[free_idx]   <= dispatch_tag;
			a_tag[free_idx] <= src_a_tag;
			b_tag[free_idx] <= src_b_tag;
			a_val[free_idx] <= dsp_a_val;
			b_val[free_idx] <= dsp_b_val;
		end
		// toward the alu
		if (sel_valid) begin
			issue_op  <= op[sel_idx];
			issue_tag <= tag[sel_idx];
			issue_a   <= a_val[sel_idx];
			issue_b   <= b_val[sel_idx];
		end
	end

endmodule

`default_nettype wire

//--- hw/ooo_backend.sv
// top level joining issue queue, reorder buffer and alu over the cdb

`timescale 1ns/1ps
`default_nettype none

module ooo_backend (
	input  wire logic               clock,
	input  wire logic               rst,
	input  wire logic               dispatch_valid,
	input  wire ooo_pkg::alu_op_t   dispatch_op,
	input  wire ooo_pkg::arch_reg_t dispatch_dest,
	input  wire logic               src_a_wait,
	input  wire ooo_pkg::rob_tag_t  src_a_tag,
	input  wire ooo_pkg::data_t     src_a_value,
	input  wire logic               src_b_wait,
	input  wire ooo_pkg::rob_tag_t  src_b_tag,
	input  wire ooo_pkg::data_t     src_b_value,
	output logic                    dispatch_free,
	output ooo_pkg::rob_tag_t       dispatch_tag,
	output ooo_pkg::rob_count_t     rob_free_count,
	output logic                    commit_valid,
	output ooo_pkg::rob_tag_t       commit_tag,
	output ooo_pkg::arch_reg_t      commit_dest,
	output ooo_pkg::data_t          commit_data
);
	import ooo_pkg::*;

	// structure status and gated strobe
	logic rs_free;
	logic rob_free;
	logic dispatch_fire;

	// rob forwarding for the two sources
	logic  lookup_a_done;
	logic  lookup_b_done;
	data_t lookup_a_value;
	data_t lookup_b_value;

	// operands as seen by the issue queue
	logic  iq_a_wait;
	logic  iq_b_wait;
	data_t iq_a_value;
	data_t iq_b_value;

	// issue path and cdb
	logic     issue_valid;
	alu_op_t  issue_op;
	rob_tag_t issue_tag;
	data_t    issue_a;
	data_t    issue_b;
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	data_t    cdb_data;

	////////////////////
	// dispatch
	////////////////////

	assign dispatch_free = rs_free & rob_free;
	// strobe while full is dropped here
	assign dispatch_fire = dispatch_valid & dispatch_free;

	// completed producer resolves now, otherwise keep waiting on its tag
	assign iq_a_wait  = src_a_wait & ~lookup_a_done;
	assign iq_a_value = src_a_wait ? lookup_a_value : src_a_value;
	assign iq_b_wait  = src_b_wait & ~lookup_b_done;
	assign iq_b_value = src_b_wait ? lookup_b_value : src_b_value;

	issue_queue u_issue_queue (
		.clock          (clock),
		.rst            (rst),
		.dispatch_valid (dispatch_fire),
		.dispatch_op    (dispatch_op),
		.dispatch_tag   (dispatch_tag),
		.src_a_wait     (iq_a_wait),
		.src_a_tag      (src_a_tag),
		.src_a_value    (iq_a_value),
		.src_b_wait     (iq_b_wait),
		.src_b_tag      (src_b_tag),
		.src_b_value    (iq_b_value),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data),
		.rs_free        (rs_free),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.issue_tag      (issue_tag),
		.issue_a        (issue_a),
		.issue_b        (issue_b)
	);

	reorder_buffer u_rob (
		.clock          (clock),
		.rst            (rst),
		.dispatch_valid (dispatch_fire),
		.dispatch_dest  (dispatch_dest),
		.alloc_tag      (dispatch_tag),
		.rob_free       (rob_free),
		.rob_free_count (rob_free_count),
		.lookup_a_tag   (src_a_tag),
		.lookup_b_tag   (src_b_tag),
		.lookup_a_done  (lookup_a_done),
		.lookup_b_done  (lookup_b_done),
		.lookup_a_value (lookup_a_value),
		.lookup_b_value (lookup_b_value),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data),
		.commit_valid   (commit_valid),
		.commit_tag     (commit_tag),
		.commit_dest    (commit_dest),
		.commit_data    (commit_data)
	);

	// single lane, no back-pressure toward the issue queue
	alu_unit u_alu (
		.clock       (clock),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_tag   (issue_tag),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data)
	);

endmodule

`default_nettype wire

//--- hw/ooo_pkg.sv
// shared typedefs for data, rob tags, registers, opcodes and counts

`default_nettype none

`include "ooo_defines.svh"

package ooo_pkg;

	////////////////////
	// datapath
	////////////////////

	// operand or result word
	typedef logic [`OOO_DATA_WIDTH-1:0] data_t;

	// index of a rob entry, also the tag of its producer
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

	// architectural destination register
	typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;

	// alu opcode, see OOO_OP_* codes
	typedef logic [2:0] alu_op_t;

	////////////////////
	// status
	////////////////////

	// one extra bit so a fully empty rob can be counted
	typedef logic [$clog2(`OOO_ROB_DEPTH):0] rob_count_t;

endpackage

`default_nettype wire

//--- hw/reorder_buffer.sv
// reorder buffer: circular tag allocator, completion, forwarding, in-order commit

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module reorder_buffer (
	input  wire logic               clock,
	input  wire logic               rst,
	input  wire logic               dispatch_valid,
	input  wire ooo_pkg::arch_reg_t dispatch_dest,
	output ooo_pkg::rob_tag_t       alloc_tag,
	output logic                    rob_free,
	output ooo_pkg::rob_count_t     rob_free_count,
	input  wire ooo_pkg::rob_tag_t  lookup_a_tag,
	input  wire ooo_pkg::rob_tag_t  lookup_b_tag,
	output logic                    lookup_a_done,
	output logic                    lookup_b_done,
	output ooo_pkg::data_t          lookup_a_value,
	output ooo_pkg::data_t          lookup_b_value,
	input  wire logic               cdb_valid,
	input  wire ooo_pkg::rob_tag_t  cdb_tag,
	input  wire ooo_pkg::data_t     cdb_data,
	output logic                    commit_valid,
	output ooo_pkg::rob_tag_t       commit_tag,
	output ooo_pkg::arch_reg_t      commit_dest,
	output ooo_pkg::data_t          commit_data
);
	import ooo_pkg::*;

	localparam int         ROB_N    = `OOO_ROB_DEPTH;
	localparam rob_count_t ROB_FULL = rob_count_t'(`OOO_ROB_DEPTH);

	// per-entry completion, cleared when the slot is allocated
	logic [ROB_N-1:0] done;

	// per-entry payload
	arch_reg_t dest [ROB_N];
	data_t     data [ROB_N];

	// oldest entry, next free entry, occupancy
	rob_tag_t   head;
	rob_tag_t   tail;
	rob_count_t count;

	// head leaves at the coming edge
	logic retire;

	////////////////////
	// allocation status
	////////////////////

	// tags are just slot indices, handed out in order
	assign alloc_tag      = tail;
	assign rob_free       = count != ROB_FULL;
	assign rob_free_count = ROB_FULL - count;

	assign retire = (count != '0) && done[head];

	////////////////////
	// operand forwarding
	////////////////////

	// only meaningful for uncommitted producers named by dispatch
	assign lookup_a_done  = done[lookup_a_tag];
	assign lookup_a_value = data[lookup_a_tag];
	assign lookup_b_done  = done[lookup_b_tag];
	assign lookup_b_value = data[lookup_b_tag];

	////////////////////
	// pointers and flags
	////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			done         <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			// new entry starts incomplete
			if (dispatch_valid) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			// cdb never names the slot being allocated
			if (cdb_valid)
				done[cdb_tag] <= 1'b1;
			if (retire)
				head <= head + 1'b1;
			count <= count + rob_count_t'(dispatch_valid) - rob_count_t'(retire);
		end
	end

	////////////////////
	// payload and commit
	////////////////////

	always_ff @(posedge clock) begin
		if (dispatch_valid)
			dest[tail] <= dispatch_dest;
		if (cdb_valid)
			data[cdb_tag] <= cdb_data;
		// commit fields line up with commit_valid
		if (retire) begin
			commit_tag  <= head;
			commit_dest <= dest[head];
			commit_data <= data[head];
		end
	end

endmodule

`default_nettype wire

//--- include/ooo_defines.svh
// width, depth and opcode macros for the out-of-order back end

`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

////////////////////
// widths and depths
////////////////////

// operand and result width
`define OOO_DATA_WIDTH 32
// reorder buffer entries, power of two so tags wrap
`define OOO_ROB_DEPTH  8
// reservation station entries
`define OOO_RS_DEPTH   4
// architectural register file size
`define OOO_ARCH_REGS  32

////////////////////
// alu opcodes
////////////////////

`define OOO_OP_ADD 3'd0
`define OOO_OP_SUB 3'd1
`define OOO_OP_AND 3'd2
`define OOO_OP_OR  3'd3
`define OOO_OP_XOR 3'd4
// signed less-than, result is 0 or 1
`define OOO_OP_SLT 3'd5
// shift left by low bits of operand b
`define OOO_OP_SLL 3'd6

`endif

//--- tb.f
+incdir+include
hw/ooo_pkg.sv
hw/issue_queue.sv
hw/reorder_buffer.sv
hw/alu_unit.sv
hw/ooo_backend.sv
dv/clock_gen.sv
dv/tb_ooo_backend.sv
